// ==== flist.f ====
+incdir+common
common/sram_pkg.sv
hw/bus_port.sv
sram/sram_ctrl.sv
sram/sram_pins.sv
hw/sram_subsys.sv
bench/sram_chip_model.sv
bench/tb_sram_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_sram_subsys \
	-o tb_sram_subsys > build.log 2>&1 \
	&& ./obj_dir/tb_sram_subsys > sim.log 2>&1 \
	|| { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "Test failures found" sim.log \
	&& { echo "simulation reported failures, see sim.log"; exit 1; } \
	|| { echo "simulation clean, see sim.log"; exit 0; }

// ==== bench/tb_sram_subsys.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sram_defs.svh"

module tb_sram_subsys;

	localparam int clk_period = 4;
	localparam int reset_cycles = 10;
	localparam int access_cycles = 4; // wb_nak low in this cycle after sampling
	localparam int err_cycles = 1;
	localparam int n_slots = 16;
	localparam int n_random = 200;
	localparam int max_accesses = 300;
	localparam int max_wait = 16;
	localparam int watchdog_ns =
		(reset_cycles + max_accesses * (access_cycles + 2) + 100) * clk_period;

	logic clk;
	logic rst;
	logic wb_stb;
	sram_pkg::bus_addr_t wb_addr;
	sram_pkg::byte_en_t wb_we;
	sram_pkg::word_t wb_din;
	sram_pkg::word_t wb_dout;
	logic wb_nak;
	logic wb_err;
	sram_pkg::chip_vec_t sram_ce_n;
	sram_pkg::chip_vec_t sram_oe_n;
	sram_pkg::chip_vec_t sram_we_n;
	sram_pkg::chip_vec_t sram_ub_n;
	sram_pkg::chip_vec_t sram_lb_n;
	sram_pkg::sram_addr_t sram_addr;
	wire [`SRAM_DW-1:0] sram_data;

	sram_pkg::word_t ref_mem [0:n_slots-1];
	integer seed;
	int errors;
	int tests_run;
	int tests_failed;
	int test_start_errors;
	sram_pkg::chip_vec_t phase_ce_n; // pins seen in the address phase
	sram_pkg::chip_vec_t phase_we_n;
	sram_pkg::chip_vec_t phase_ub_n;
	sram_pkg::chip_vec_t phase_lb_n;
	sram_pkg::chip_vec_t ce_n_seen; // low bit if that chip was ever enabled

	sram_subsys UUT (
		.clk(clk),
		.rst(rst),
		.wb_stb(wb_stb),
		.wb_addr(wb_addr),
		.wb_we(wb_we),
		.wb_din(wb_din),
		.wb_dout(wb_dout),
		.wb_nak(wb_nak),
		.wb_err(wb_err),
		.sram_ce_n(sram_ce_n),
		.sram_oe_n(sram_oe_n),
		.sram_we_n(sram_we_n),
		.sram_ub_n(sram_ub_n),
		.sram_lb_n(sram_lb_n),
		.sram_addr(sram_addr),
		.sram_data(sram_data)
	);

	for (genvar i = 0; i < `SRAM_CHIPS; i++) begin : g_chip
		sram_chip_model chip (
			.ce_n(sram_ce_n[i]),
			.oe_n(sram_oe_n[i]),
			.we_n(sram_we_n[i]),
			.ub_n(sram_ub_n[i]),
			.lb_n(sram_lb_n[i]),
			.addr(sram_addr),
			.data(sram_data[16*i +: 16])
		);
	end

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		#(watchdog_ns);
		$display("timeout: run stopped after %0d ns", watchdog_ns);
		$display("Test failures found");
		$finish;
	end

	task automatic check_word(input string name, input sram_pkg::word_t got,
		input sram_pkg::word_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_chips(input string name, input sram_pkg::chip_vec_t got,
		input sram_pkg::chip_vec_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input sram_pkg::sram_addr_t got,
		input sram_pkg::sram_addr_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_cycles(input int got, input int exp);
		if (got != exp) begin
			$display("wrong timing: access completed in cycle %0d, expected cycle %0d", got, exp);
			errors++;
		end
	endtask

	// spread over the whole window, word aligned
	function automatic sram_pkg::bus_addr_t slot_addr(input int slot);
		return sram_pkg::bus_addr_t'(slot * 32'h0002_4924) & 32'h003f_fffc;
	endfunction

	function automatic sram_pkg::word_t merge_word(input sram_pkg::word_t old_w,
		input sram_pkg::word_t new_w, input sram_pkg::byte_en_t we);
		sram_pkg::word_t w;
		int b;
		w = old_w;
		for (b = 0; b < 4; b++)
			if (we[b])
				w[b*8 +: 8] = new_w[b*8 +: 8];
		return w;
	endfunction

	// chip 0 holds bytes 1:0, chip 1 bytes 3:2, chip 2 is never written
	function automatic void write_pins_for(input sram_pkg::byte_en_t we,
		output sram_pkg::chip_vec_t we_n, output sram_pkg::chip_vec_t ub_n,
		output sram_pkg::chip_vec_t lb_n);
		ub_n = 3'b111;
		lb_n = 3'b111;
		ub_n[0] = !we[1];
		lb_n[0] = !we[0];
		ub_n[1] = !we[3];
		lb_n[1] = !we[2];
		we_n = {1'b1, ub_n[1] & lb_n[1], ub_n[0] & lb_n[0]};
	endfunction

	task automatic start_req(input sram_pkg::bus_addr_t a, input sram_pkg::byte_en_t we,
		input sram_pkg::word_t d);
		wb_stb = 1'b1;
		wb_addr = a;
		wb_we = we;
		wb_din = d;
	endtask

	task automatic end_req();
		wb_stb = 1'b0;
		wb_addr = '0;
		wb_we = '0;
		wb_din = '0;
		@(posedge clk);
		#1;
	endtask

	task automatic wait_done(output sram_pkg::word_t rd, output logic err, output int cycles);
		cycles = 0;
		ce_n_seen = 3'b111;
		do begin
			@(posedge clk);
			#1;
			cycles++;
			ce_n_seen = ce_n_seen & sram_ce_n;
			if (cycles == 2) begin
				phase_ce_n = sram_ce_n;
				phase_we_n = sram_we_n;
				phase_ub_n = sram_ub_n;
				phase_lb_n = sram_lb_n;
			end
		end while (wb_nak && cycles < max_wait);
		if (wb_nak) begin
			$display("no completion: wb_nak stayed high for %0d cycles", cycles);
			errors++;
		end
		rd = wb_dout;
		err = wb_err;
	endtask

	task automatic check_result(input int slot, input sram_pkg::byte_en_t we,
		input sram_pkg::word_t d, input sram_pkg::word_t rd, input logic err, input int cycles);
		check_cycles(cycles, access_cycles);
		check_bit("wb_err", err, 1'b0);
		if (we == '0)
			check_word("wb_dout", rd, ref_mem[slot]);
		else begin
			check_word("wb_dout", rd, '0); // writes return zero
			ref_mem[slot] = merge_word(ref_mem[slot], d, we);
		end
	endtask

	task automatic access_slot(input int slot, input sram_pkg::byte_en_t we,
		input sram_pkg::word_t d);
		sram_pkg::word_t rd;
		logic err;
		int cycles;
		start_req(slot_addr(slot), we, d);
		wait_done(rd, err, cycles);
		end_req();
		check_result(slot, we, d, rd, err, cycles);
	endtask

	task automatic access_outside(input sram_pkg::bus_addr_t a, input sram_pkg::byte_en_t we,
		input sram_pkg::word_t d);
		sram_pkg::word_t rd;
		logic err;
		int cycles;
		start_req(a, we, d);
		wait_done(rd, err, cycles);
		end_req();
		ce_n_seen = ce_n_seen & sram_ce_n; // an address phase would show here
		check_cycles(cycles, err_cycles);
		check_bit("wb_err", err, 1'b1);
		check_word("wb_dout", rd, '0);
		check_chips("sram_ce_n", ce_n_seen, 3'b111);
	endtask

	task automatic check_idle_pins();
		check_chips("sram_ce_n", sram_ce_n, 3'b111);
		check_chips("sram_oe_n", sram_oe_n, 3'b111);
		check_chips("sram_we_n", sram_we_n, 3'b111); // bus released
		check_chips("sram_ub_n", sram_ub_n, 3'b111);
		check_chips("sram_lb_n", sram_lb_n, 3'b111);
		check_addr("sram_addr", sram_addr, '0);
		check_bit("wb_nak", wb_nak, 1'b1);
		check_bit("wb_err", wb_err, 1'b0);
		check_word("wb_dout", wb_dout, '0);
	endtask

	task automatic begin_test();
		test_start_errors = errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_start_errors)
			$display("%s: pass", name);
		else begin
			tests_failed++;
			$display("%s: FAIL with %0d errors", name, errors - test_start_errors);
		end
	endtask

	task automatic test_reset();
		int c;
		rst = 1'b1;
		for (c = 0; c < reset_cycles; c++) begin
			@(posedge clk);
			#1;
			check_idle_pins();
		end
		rst = 1'b0;
		@(posedge clk);
		#1;
		check_idle_pins();
	endtask

	task automatic test_full_word();
		access_slot(0, 4'hf, 32'h3c5a_96e1);
		access_slot(0, 4'h0, '0);
		access_slot(1, 4'hf, 32'hc0de_7a11);
		access_slot(1, 4'h0, '0);
		access_slot(0, 4'h0, '0);
	endtask

	task automatic test_byte_lanes();
		sram_pkg::byte_en_t lane_we [5] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0110};
		sram_pkg::chip_vec_t exp_we_n;
		sram_pkg::chip_vec_t exp_ub_n;
		sram_pkg::chip_vec_t exp_lb_n;
		int i;
		access_slot(8, 4'hf, 32'h1122_3344);
		for (i = 0; i < 5; i++) begin
			access_slot(8, lane_we[i], 32'hc3c3_c3c3 + i * 32'h0101_0101);
			write_pins_for(lane_we[i], exp_we_n, exp_ub_n, exp_lb_n);
			check_chips("sram_ce_n", phase_ce_n, 3'b000);
			check_chips("sram_we_n", phase_we_n, exp_we_n);
			check_chips("sram_ub_n", phase_ub_n, exp_ub_n);
			check_chips("sram_lb_n", phase_lb_n, exp_lb_n);
			access_slot(8, 4'h0, '0);
		end
	endtask

	task automatic test_back_to_back();
		int op_slot [8];
		sram_pkg::byte_en_t op_we [8];
		sram_pkg::word_t op_data [8];
		sram_pkg::word_t rd;
		logic err;
		int cycles;
		int i;
		for (i = 0; i < 8; i++) begin
			if (i % 2 == 0) begin
				op_slot[i] = 4 + i / 2;
				op_we[i] = 4'hf;
				op_data[i] = $random(seed);
			end else begin
				op_slot[i] = (i == 1) ? 0 : 4 + (i - 3) / 2; // a slot written earlier
				op_we[i] = 4'h0;
				op_data[i] = '0;
			end
		end
		start_req(slot_addr(op_slot[0]), op_we[0], op_data[0]);
		for (i = 0; i < 8; i++) begin
			wait_done(rd, err, cycles);
			if (i < 7)
				start_req(slot_addr(op_slot[i+1]), op_we[i+1], op_data[i+1]);
			else
				end_req();
			check_result(op_slot[i], op_we[i], op_data[i], rd, err, cycles);
		end
	endtask

	task automatic test_out_of_window();
		int c;
		access_outside(slot_addr(0) | (32'h1 << `SRAM_WIN_BITS), 4'hf, 32'hffff_ffff);
		access_outside(slot_addr(1) | 32'h8000_0000, 4'h0, '0);
		for (c = 0; c < 3; c++) begin
			@(posedge clk);
			#1;
			check_chips("sram_ce_n", sram_ce_n, 3'b111);
		end
		access_slot(0, 4'h0, '0); // alias must not have been written
		access_slot(1, 4'h0, '0);
	endtask

	task automatic test_random();
		sram_pkg::byte_en_t we;
		int slot;
		int i;
		for (i = 0; i < n_slots; i++)
			access_slot(i, 4'hf, $random(seed));
		for (i = 0; i < n_random; i++) begin
			slot = $unsigned($random(seed)) % n_slots;
			we = sram_pkg::byte_en_t'($random(seed));
			if ($unsigned($random(seed)) % 3 == 0)
				we = '0; // roughly one read in three
			access_slot(slot, we, $random(seed));
		end
		for (i = 0; i < n_slots; i++)
			access_slot(i, 4'h0, '0);
	endtask

	initial begin
		seed = 32'h9c78_1f04;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		rst = 1'b1;
		wb_stb = 1'b0;
		wb_addr = '0;
		wb_we = '0;
		wb_din = '0;
		begin_test();
		test_reset();
		end_test("reset state");
		begin_test();
		test_full_word();
		end_test("full word write and read");
		begin_test();
		test_byte_lanes();
		end_test("byte lane merge");
		begin_test();
		test_back_to_back();
		end_test("back to back");
		begin_test();
		test_out_of_window();
		end_test("out of window");
		begin_test();
		test_random();
		end_test("random traffic");
		$display("summary: %0d tests, %0d passed, %0d failed, %0d check errors",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/sram_chip_model.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sram_defs.svh"

module sram_chip_model (
	input wire ce_n,
	input wire oe_n,
	input wire we_n,
	input wire ub_n,
	input wire lb_n,
	input wire sram_pkg::sram_addr_t addr,
	inout wire [15:0] data
);

	localparam int depth = 1 << `SRAM_AW;

	logic [15:0] mem [0:depth-1];
	logic rd_en;

	assign rd_en = !ce_n && !oe_n && we_n;

	// each byte lane drives on its own strobe
	assign data[15:8] = (rd_en && !ub_n) ? mem[addr][15:8] : 8'hzz;
	assign data[7:0] = (rd_en && !lb_n) ? mem[addr][7:0] : 8'hzz;

	// writes land once the pins have settled after any change
	always begin
		@(ce_n or we_n or ub_n or lb_n or addr or data);
		#0.5;
		if (!ce_n && !we_n) begin
			if (!ub_n)
				mem[addr][15:8] = data[15:8];
			if (!lb_n)
				mem[addr][7:0] = data[7:0];
		end
	end

endmodule

`default_nettype wire

// ==== hw/sram_subsys.sv ====
`timescale 1ns/10ps
`default_nettype none

module sram_subsys (
	input wire clk,
	input wire rst,

	input wire wb_stb,
	input wire sram_pkg::bus_addr_t wb_addr,
	input wire sram_pkg::byte_en_t wb_we,
	input wire sram_pkg::word_t wb_din,
	output sram_pkg::word_t wb_dout,
	output logic wb_nak,
	output logic wb_err,

	output sram_pkg::chip_vec_t sram_ce_n,
	output sram_pkg::chip_vec_t sram_oe_n,
	output sram_pkg::chip_vec_t sram_we_n,
	output sram_pkg::chip_vec_t sram_ub_n,
	output sram_pkg::chip_vec_t sram_lb_n,
	output sram_pkg::sram_addr_t sram_addr,
	inout wire sram_pkg::sram_data_t sram_data
);

	logic req;
	logic done;
	logic capture;
	sram_pkg::byte_en_t req_we;
	sram_pkg::sram_addr_t req_addr;
	sram_pkg::word_t req_data;
	sram_pkg::word_t rdata;
	sram_pkg::chip_vec_t ce_n;
	sram_pkg::chip_vec_t oe_n;
	sram_pkg::chip_vec_t we_n;
	sram_pkg::chip_vec_t ub_n;
	sram_pkg::chip_vec_t lb_n;
	sram_pkg::sram_addr_t addr;
	sram_pkg::sram_data_t wdata;

	bus_port u_bus_port (
		.clk(clk),
		.rst(rst),
		.wb_stb(wb_stb),
		.wb_addr(wb_addr),
		.wb_we(wb_we),
		.wb_din(wb_din),
		.wb_dout(wb_dout),
		.wb_nak(wb_nak),
		.wb_err(wb_err),
		.req(req),
		.req_we(req_we),
		.req_addr(req_addr),
		.req_data(req_data),
		.done(done),
		.rdata(rdata)
	);

	sram_ctrl u_sram_ctrl (
		.clk(clk),
		.rst(rst),
		.req(req),
		.req_we(req_we),
		.req_addr(req_addr),
		.req_data(req_data),
		.done(done),
		.ce_n(ce_n),
		.oe_n(oe_n),
		.we_n(we_n),
		.ub_n(ub_n),
		.lb_n(lb_n),
		.addr(addr),
		.wdata(wdata),
		.capture(capture)
	);

	sram_pins u_sram_pins (
		.clk(clk),
		.rst(rst),
		.ce_n(ce_n),
		.oe_n(oe_n),
		.we_n(we_n),
		.ub_n(ub_n),
		.lb_n(lb_n),
		.addr(addr),
		.wdata(wdata),
		.capture(capture),
		.rdata(rdata),
		.sram_ce_n(sram_ce_n),
		.sram_oe_n(sram_oe_n),
		.sram_we_n(sram_we_n),
		.sram_ub_n(sram_ub_n),
		.sram_lb_n(sram_lb_n),
		.sram_addr(sram_addr),
		.sram_data(sram_data)
	);

endmodule

`default_nettype wire

// ==== sram/sram_pins.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sram_defs.svh"

module sram_pins (
	input wire clk,
	input wire rst,

	input wire sram_pkg::chip_vec_t ce_n,
	input wire sram_pkg::chip_vec_t oe_n,
	input wire sram_pkg::chip_vec_t we_n,
	input wire sram_pkg::chip_vec_t ub_n,
	input wire sram_pkg::chip_vec_t lb_n,
	input wire sram_pkg::sram_addr_t addr,
	input wire sram_pkg::sram_data_t wdata,
	input wire capture,
	output sram_pkg::word_t rdata,

	output sram_pkg::chip_vec_t sram_ce_n,
	output sram_pkg::chip_vec_t sram_oe_n,
	output sram_pkg::chip_vec_t sram_we_n,
	output sram_pkg::chip_vec_t sram_ub_n,
	output sram_pkg::chip_vec_t sram_lb_n,
	output sram_pkg::sram_addr_t sram_addr,
	inout wire sram_pkg::sram_data_t sram_data
);

	sram_pkg::sram_data_t dout_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			sram_ce_n <= '1;
			sram_oe_n <= '1;
			sram_we_n <= '1; // bus released
			sram_ub_n <= '1;
			sram_lb_n <= '1;
			sram_addr <= '0;
		end else begin
			sram_ce_n <= ce_n;
			sram_oe_n <= oe_n;
			sram_we_n <= we_n;
			sram_ub_n <= ub_n;
			sram_lb_n <= lb_n;
			sram_addr <= addr;
		end
	end

	always_ff @(posedge clk) begin
		dout_q <= wdata;
	end

	// drive only while some chip is being written
	assign sram_data = (&sram_we_n) ? 'z : dout_q;

	always_ff @(posedge clk) begin
		if (capture)
			rdata <= sram_data[`SRAM_BUS_W-1:0]; // chips 0 and 1
	end

endmodule

`default_nettype wire

// ==== sram/sram_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module sram_ctrl (
	input wire clk,
	input wire rst,

	input wire req,
	input wire sram_pkg::byte_en_t req_we,
	input wire sram_pkg::sram_addr_t req_addr,
	input wire sram_pkg::word_t req_data,
	output logic done,

	// control values for the next pin cycle
	output sram_pkg::chip_vec_t ce_n,
	output sram_pkg::chip_vec_t oe_n,
	output sram_pkg::chip_vec_t we_n,
	output sram_pkg::chip_vec_t ub_n,
	output sram_pkg::chip_vec_t lb_n,
	output sram_pkg::sram_addr_t addr,
	output sram_pkg::sram_data_t wdata,
	output logic capture
);

	localparam sram_pkg::chip_vec_t chips_off = 3'b111;
	localparam sram_pkg::chip_vec_t rd_chips_n = 3'b100; // chips 0 and 1
	localparam sram_pkg::chip_vec_t rd_bytes_n = 3'b000;
	localparam sram_pkg::chip_vec_t wr_chips_n = 3'b000;

	sram_pkg::ctrl_state_t state;
	sram_pkg::ctrl_state_t state_nx;
	sram_pkg::chip_vec_t wr_we_n;
	sram_pkg::chip_vec_t wr_ub_n;
	sram_pkg::chip_vec_t wr_lb_n;

	always_comb begin
		state_nx = state;
		case (state)
			sram_pkg::st_idle: begin
				if (req)
					state_nx = (|req_we) ? sram_pkg::st_write : sram_pkg::st_read;
			end
			sram_pkg::st_read: state_nx = sram_pkg::st_read_hold;
			sram_pkg::st_read_hold: state_nx = sram_pkg::st_idle;
			sram_pkg::st_write: state_nx = sram_pkg::st_write_hold;
			sram_pkg::st_write_hold: state_nx = sram_pkg::st_idle;
			default: state_nx = sram_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= sram_pkg::st_idle;
		else
			state <= state_nx;
	end

	// byte enables 1:0 go to chip 0, 3:2 to chip 1, chip 2 never written
	assign wr_we_n = {1'b1, ~(req_we[3] | req_we[2]), ~(req_we[1] | req_we[0])};
	assign wr_ub_n = {1'b1, ~req_we[3], ~req_we[1]};
	assign wr_lb_n = {1'b1, ~req_we[2], ~req_we[0]};

	// pattern for the cycle the pins will show next
	always_comb begin
		ce_n = chips_off;
		oe_n = chips_off;
		we_n = chips_off;
		ub_n = chips_off;
		lb_n = chips_off;
		addr = '0;
		wdata = '0;
		case (state_nx)
			sram_pkg::st_read, sram_pkg::st_read_hold: begin
				ce_n = rd_chips_n;
				oe_n = rd_chips_n;
				ub_n = rd_bytes_n;
				lb_n = rd_bytes_n;
				addr = req_addr;
			end
			sram_pkg::st_write, sram_pkg::st_write_hold: begin
				ce_n = wr_chips_n;
				we_n = wr_we_n;
				ub_n = wr_ub_n;
				lb_n = wr_lb_n;
				addr = req_addr;
				wdata = sram_pkg::sram_data_t'(req_data); // upper chip gets zeros
			end
			default: begin
				ce_n = chips_off;
			end
		endcase
	end

	// pins are in the data phase while in a hold state
	assign capture = (state == sram_pkg::st_read_hold);
	assign done = (state == sram_pkg::st_read_hold) || (state == sram_pkg::st_write_hold);

endmodule

`default_nettype wire

// ==== hw/bus_port.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sram_defs.svh"

module bus_port (
	input wire clk,
	input wire rst,

	input wire wb_stb,
	input wire sram_pkg::bus_addr_t wb_addr,
	input wire sram_pkg::byte_en_t wb_we,
	input wire sram_pkg::word_t wb_din,
	output sram_pkg::word_t wb_dout,
	output logic wb_nak,
	output logic wb_err,

	output logic req,
	output sram_pkg::byte_en_t req_we,
	output sram_pkg::sram_addr_t req_addr,
	output sram_pkg::word_t req_data,
	input wire done,
	input wire sram_pkg::word_t rdata
);

	typedef enum logic [1:0] {
		bp_idle,
		bp_busy,
		bp_complete
	} bp_state_t;

	bp_state_t state;
	logic err_q;
	logic out_of_win;

	assign out_of_win = |wb_addr[`SRAM_BUS_W-1:`SRAM_WIN_BITS];

	// completion and idle both sample the strobe at their closing edge
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= bp_idle;
			req <= 1'b0;
			err_q <= 1'b0;
		end else begin
			req <= 1'b0; // one cycle pulse
			case (state)
				bp_idle, bp_complete: begin
					if (wb_stb) begin
						err_q <= out_of_win;
						if (out_of_win)
							state <= bp_complete; // error answered at once
						else begin
							state <= bp_busy;
							req <= 1'b1;
						end
					end else
						state <= bp_idle;
				end
				bp_busy: begin
					if (done)
						state <= bp_complete;
				end
				default: state <= bp_idle;
			endcase
		end
	end

	// request payload held until completion
	always_ff @(posedge clk) begin
		if ((state != bp_busy) && wb_stb) begin
			req_we <= wb_we;
			req_addr <= wb_addr[`SRAM_WIN_BITS-1:2];
			req_data <= wb_din;
		end
	end

	assign wb_nak = (state != bp_complete);
	assign wb_err = (state == bp_complete) && err_q;
	assign wb_dout = ((state == bp_complete) && !err_q && (req_we == '0)) ? rdata : '0;

endmodule

`default_nettype wire

// ==== common/sram_pkg.sv ====
`default_nettype none

`include "sram_defs.svh"

package sram_pkg;

	typedef logic [`SRAM_BUS_W-1:0] word_t;
	typedef logic [`SRAM_BUS_W-1:0] bus_addr_t;

	typedef logic [`SRAM_AW-1:0] sram_addr_t; // bus address bits 21:2

	typedef logic [`SRAM_BUS_W/8-1:0] byte_en_t; // bit 0 is the low byte

	typedef logic [`SRAM_CHIPS-1:0] chip_vec_t; // active low, bit i is chip i

	typedef logic [`SRAM_DW-1:0] sram_data_t; // chip 0 on 15:0

	// controller sequence, one address phase then one data phase
	typedef enum logic [2:0] {
		st_idle,
		st_read,
		st_read_hold,
		st_write,
		st_write_hold
	} ctrl_state_t;

endpackage

`default_nettype wire

// ==== common/sram_defs.svh ====
`ifndef SRAM_DEFS_SVH
`define SRAM_DEFS_SVH

// strobe bus side

`define SRAM_BUS_W 32 // one bus word

// sram bank side

`define SRAM_AW 20 // word address per chip

`define SRAM_CHIPS 3 // chips in the bank

`define SRAM_DW 48 // shared data bus, 16 bits per chip

// low address bits that fall inside the sram window
// anything set above bit 21 is out of window
`define SRAM_WIN_BITS 22

`endif
